/* Makefile */
VERILATOR ?= verilator
TOP       ?= brew_menu_tb
FILELIST  ?= brew_menu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* brew_menu.f */
logic/brew_menu_pkg.sv
logic/button_debouncer.sv
logic/button_conditioner.sv
logic/option_selector.sv
logic/menu_fsm.sv
logic/brew_menu_top.sv
sim/brew_menu_sva.sv
sim/brew_menu_tb.sv

/* logic/brew_menu_pkg.sv */
/*
 * Brew menu package
 * Menu states, selection lists, button and control bundles and the
 * default hardware timing for the coffee machine menu
 */
`default_nettype none

package brew_menu_pkg;

    // ==============================
    // Menu states
    // ==============================
    // Code 8 is left free, the old settings screen
    typedef enum logic [3:0] {
        ST_SPLASH            = 4'd0,
        ST_CHECK_ERRORS      = 4'd1,
        ST_COFFEE_SELECT     = 4'd2,
        ST_DRINK_SELECT      = 4'd3,
        ST_SIZE_SELECT       = 4'd4,
        ST_CONFIRM           = 4'd5,
        ST_BREWING           = 4'd6,
        ST_COMPLETE          = 4'd7,
        ST_ERROR             = 4'd9,
        ST_INSUFFICIENT      = 4'd10,
        ST_ABORT_CONFIRM     = 4'd11,
        ST_MAINTENANCE       = 4'd12,
        ST_MAINT_OPTIONS     = 4'd13,
        ST_MAINT_VIEW_ERRORS = 4'd14,
        ST_MAINT_MANUAL_CHECK = 4'd15
    } menu_state_e;

    // ==============================
    // Selection lists
    // ==============================
    typedef enum logic [2:0] {
        DRINK_BLACK_COFFEE  = 3'd0,
        DRINK_COFFEE_CREAM  = 3'd1,
        DRINK_LATTE         = 3'd2,
        DRINK_MOCHA         = 3'd3,
        DRINK_HOT_CHOCOLATE = 3'd4
    } drink_e;

    typedef enum logic [1:0] {
        SIZE_8OZ  = 2'd0,
        SIZE_12OZ = 2'd1,
        SIZE_16OZ = 2'd2
    } size_e;

    typedef enum logic [1:0] {
        MAINT_VIEW_ERRORS  = 2'd0,
        MAINT_MANUAL_CHECK = 2'd1,
        MAINT_SERVICE_TIME = 2'd2,
        MAINT_EXIT         = 2'd3
    } maint_opt_e;

    // List lengths for cursor wrap
    localparam int NUM_COFFEE_BINS   = 2;
    localparam int NUM_DRINKS        = 5;
    localparam int NUM_SIZES         = 3;
    localparam int NUM_MAINT_OPTIONS = 4;

    // Board timing at 50 MHz: 20 ms, 50 ms, 10 s
    localparam int DEF_DEBOUNCE_CYCLES      = 1_000_000;
    localparam int DEF_COMBO_HOLD_CYCLES    = 2_500_000;
    localparam int DEF_INSUFFICIENT_TIMEOUT = 500_000_000;

    // ==============================
    // Bundles
    // ==============================
    typedef struct packed {
        logic cancel;
        logic left;
        logic right;
        logic select;
    } button_raw_t;

    // Press fields and combo are one-cycle pulses
    typedef struct packed {
        logic cancel;
        logic left;
        logic right;
        logic select;
        logic combo;
    } button_events_t;

    typedef struct packed {
        logic brewing_active;
        logic error_present;
        logic recipe_valid;
        logic can_make_coffee;
        logic pressure_ready;
    } machine_status_t;

    typedef struct packed {
        logic [2:0] coffee_bin;
        drink_e     drink;
        size_e      size;
        maint_opt_e maint_opt;
    } selection_t;

    typedef struct packed {
        logic start_brewing;
        logic maintenance_mode;
        logic manual_check;
        logic display_refresh;
    } menu_ctrl_t;

endpackage

`default_nettype wire

/* logic/brew_menu_top.sv */
/*
 * Brew menu top
 * Button conditioning feeding the option cursors and the menu FSM
 */
`timescale 1ns/1ps
`default_nettype none

module brew_menu_top #(
    parameter int DEBOUNCE_CYCLES      = brew_menu_pkg::DEF_DEBOUNCE_CYCLES,
    parameter int COMBO_HOLD_CYCLES    = brew_menu_pkg::DEF_COMBO_HOLD_CYCLES,
    parameter int INSUFFICIENT_TIMEOUT = brew_menu_pkg::DEF_INSUFFICIENT_TIMEOUT
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  brew_menu_pkg::button_raw_t     buttons,
    input  brew_menu_pkg::machine_status_t status,
    output brew_menu_pkg::menu_state_e     menu_state,
    output brew_menu_pkg::selection_t      selection,
    output brew_menu_pkg::menu_ctrl_t      ctrl
);

    import brew_menu_pkg::*;

    // Press and combo pulses, shared by cursors and FSM
    button_events_t events;

    button_conditioner #(
        .DEBOUNCE_CYCLES  (DEBOUNCE_CYCLES),
        .COMBO_HOLD_CYCLES(COMBO_HOLD_CYCLES)
    ) i_conditioner (
        .clk    (clk),
        .rst_n  (rst_n),
        .buttons(buttons),
        .events (events)
    );

    option_selector i_selector (
        .clk       (clk),
        .rst_n     (rst_n),
        .menu_state(menu_state),
        .events    (events),
        .selection (selection)
    );

    // Maintenance cursor steers the options screen
    menu_fsm #(
        .INSUFFICIENT_TIMEOUT(INSUFFICIENT_TIMEOUT)
    ) i_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .events      (events),
        .status      (status),
        .maint_option(selection.maint_opt),
        .menu_state  (menu_state),
        .ctrl        (ctrl)
    );

endmodule

`default_nettype wire

/* logic/button_conditioner.sv */
/*
 * Button conditioner
 * Debounces the four buttons, makes press pulses and times the hidden
 * left/right plus select combination
 */
`timescale 1ns/1ps
`default_nettype none

module button_conditioner #(
    parameter int DEBOUNCE_CYCLES   = brew_menu_pkg::DEF_DEBOUNCE_CYCLES,
    parameter int COMBO_HOLD_CYCLES = brew_menu_pkg::DEF_COMBO_HOLD_CYCLES
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  brew_menu_pkg::button_raw_t    buttons,
    output brew_menu_pkg::button_events_t events
);

    import brew_menu_pkg::*;

    localparam int HOLD_W = $clog2(COMBO_HOLD_CYCLES) + 1;
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(COMBO_HOLD_CYCLES - 1);

    logic [3:0]        clean_vec;
    button_raw_t       clean;
    button_raw_t       clean_q;
    logic              combo_held;
    logic [HOLD_W-1:0] hold_cnt;

    // ==============================
    // Debounce
    // ==============================
    for (genvar i = 0; i < 4; i++) begin : g_db
        button_debouncer #(
            .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
        ) i_debouncer (
            .clk  (clk),
            .rst_n(rst_n),
            .raw  (buttons[i]),
            .clean(clean_vec[i])
        );
    end

    // Back to named fields
    assign clean = clean_vec;

    // Either arrow together with select
    assign combo_held = (clean.left | clean.right) & clean.select;

    // ==============================
    // Press pulses and combo timer
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clean_q  <= '0;
            events   <= '0;
            hold_cnt <= '0;
        end else begin
            clean_q <= clean;
            // Rising edges of the clean levels
            events.cancel <= clean.cancel & ~clean_q.cancel;
            events.left   <= clean.left   & ~clean_q.left;
            events.right  <= clean.right  & ~clean_q.right;
            events.select <= clean.select & ~clean_q.select;
            if (!combo_held) begin
                // Released, start from scratch
                hold_cnt     <= '0;
                events.combo <= 1'b0;
            end else if (hold_cnt == HOLD_LAST) begin
                // Fire and restart for a repeat
                hold_cnt     <= '0;
                events.combo <= 1'b1;
            end else begin
                hold_cnt     <= hold_cnt + 1'b1;
                events.combo <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/button_debouncer.sv */
/*
 * Button debouncer
 * Takes a new raw level only once it has held for DEBOUNCE_CYCLES
 */
`timescale 1ns/1ps
`default_nettype none

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = brew_menu_pkg::DEF_DEBOUNCE_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    input  logic raw,
    output logic clean
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES) + 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    // Length of the current mismatch run
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            clean <= 1'b0;
        end else if (raw == clean) begin
            // Levels agree again, glitch thrown away
            cnt <= '0;
        end else if (cnt == CNT_LAST) begin
            // Held long enough
            clean <= raw;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/menu_fsm.sv */
/*
 * Menu state machine
 * Brewing flow, error and resource screens, hidden maintenance menu,
 * and the brew, maintenance, manual check and refresh controls
 */
`timescale 1ns/1ps
`default_nettype none

module menu_fsm #(
    parameter int INSUFFICIENT_TIMEOUT = brew_menu_pkg::DEF_INSUFFICIENT_TIMEOUT
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  brew_menu_pkg::button_events_t  events,
    input  brew_menu_pkg::machine_status_t status,
    input  brew_menu_pkg::maint_opt_e      maint_option,
    output brew_menu_pkg::menu_state_e     menu_state,
    output brew_menu_pkg::menu_ctrl_t      ctrl
);

    import brew_menu_pkg::*;

    localparam int INS_W = $clog2(INSUFFICIENT_TIMEOUT) + 1;
    localparam logic [INS_W-1:0] INS_LAST = INS_W'(INSUFFICIENT_TIMEOUT - 1);

    menu_state_e      next_state;
    menu_state_e      return_state;
    logic [INS_W-1:0] insuff_cnt;
    logic             brew_started;
    logic             state_changed;

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        next_state = menu_state;
        case (menu_state)
            ST_SPLASH: begin
                if (events.combo) begin
                    next_state = ST_MAINTENANCE;
                end else if (events.select && !status.error_present) begin
                    next_state = ST_CHECK_ERRORS;
                end
            end
            ST_CHECK_ERRORS: begin
                // Waits here until the machine is ready
                if (events.combo) begin
                    next_state = ST_MAINTENANCE;
                end else if (status.error_present) begin
                    next_state = ST_ERROR;
                end else if (status.pressure_ready && status.can_make_coffee) begin
                    next_state = ST_COFFEE_SELECT;
                end else if (events.cancel) begin
                    next_state = ST_SPLASH;
                end
            end
            ST_COFFEE_SELECT: begin
                if (events.combo) begin
                    next_state = ST_MAINTENANCE;
                end else if (events.select) begin
                    next_state = ST_DRINK_SELECT;
                end else if (events.cancel) begin
                    next_state = ST_SPLASH;
                end
            end
            ST_DRINK_SELECT: begin
                if (events.combo) begin
                    next_state = ST_MAINTENANCE;
                end else if (events.select) begin
                    next_state = ST_SIZE_SELECT;
                end else if (events.cancel) begin
                    next_state = ST_COFFEE_SELECT;
                end
            end
            ST_SIZE_SELECT: begin
                if (events.combo) begin
                    next_state = ST_MAINTENANCE;
                end else if (events.select) begin
                    next_state = ST_CONFIRM;
                end else if (events.cancel) begin
                    next_state = ST_DRINK_SELECT;
                end
            end
            ST_CONFIRM: begin
                if (events.combo) begin
                    next_state = ST_MAINTENANCE;
                end else if (events.select) begin
                    next_state = status.recipe_valid ? ST_BREWING : ST_INSUFFICIENT;
                end else if (events.cancel) begin
                    next_state = ST_SIZE_SELECT;
                end
            end
            ST_INSUFFICIENT: begin
                // Timed message, cancel cuts it short
                if (insuff_cnt >= INS_LAST || events.cancel) begin
                    next_state = return_state;
                end
            end
            ST_BREWING: begin
                // Only abort or a real end of brew leave here
                if (events.cancel) begin
                    next_state = ST_ABORT_CONFIRM;
                end else if (brew_started && !status.brewing_active) begin
                    next_state = ST_COMPLETE;
                end
            end
            ST_ABORT_CONFIRM: begin
                if (events.select) begin
                    next_state = ST_SPLASH;
                end else if (events.cancel) begin
                    next_state = ST_BREWING;
                end
            end
            ST_COMPLETE: begin
                // Any key
                if (events.select || events.cancel || events.left || events.right) begin
                    next_state = ST_SPLASH;
                end
            end
            ST_ERROR: begin
                if (events.combo) begin
                    next_state = ST_MAINTENANCE;
                end else if (!status.error_present && status.can_make_coffee) begin
                    next_state = ST_SPLASH;
                end else if (events.cancel) begin
                    next_state = ST_SPLASH;
                end
            end
            // Maintenance entry lasts one cycle
            ST_MAINTENANCE: begin
                next_state = ST_MAINT_OPTIONS;
            end
            ST_MAINT_OPTIONS: begin
                if (events.select) begin
                    case (maint_option)
                        MAINT_VIEW_ERRORS:  next_state = ST_MAINT_VIEW_ERRORS;
                        MAINT_MANUAL_CHECK: next_state = ST_MAINT_MANUAL_CHECK;
                        // Service time shares the error view
                        MAINT_SERVICE_TIME: next_state = ST_MAINT_VIEW_ERRORS;
                        MAINT_EXIT:         next_state = ST_SPLASH;
                    endcase
                end else if (events.cancel) begin
                    next_state = ST_SPLASH;
                end
            end
            ST_MAINT_VIEW_ERRORS: begin
                if (events.cancel) begin
                    next_state = ST_MAINT_OPTIONS;
                end
            end
            ST_MAINT_MANUAL_CHECK: begin
                if (events.select || events.cancel) begin
                    next_state = ST_MAINT_OPTIONS;
                end
            end
            default: begin
                // Unused code 8
                next_state = ST_SPLASH;
            end
        endcase
    end

    // ==============================
    // State and side registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            menu_state    <= ST_SPLASH;
            state_changed <= 1'b0;
            return_state  <= ST_CONFIRM;
            insuff_cnt    <= '0;
            brew_started  <= 1'b0;
        end else begin
            menu_state    <= next_state;
            state_changed <= (next_state != menu_state);
            // Remember where the resource message came from
            if (next_state == ST_INSUFFICIENT && menu_state != ST_INSUFFICIENT) begin
                return_state <= menu_state;
            end
            insuff_cnt <= (menu_state == ST_INSUFFICIENT) ? insuff_cnt + 1'b1 : '0;
            // Brew guard, set once the machine reports activity
            if (menu_state != ST_BREWING) begin
                brew_started <= 1'b0;
            end else if (status.brewing_active) begin
                brew_started <= 1'b1;
            end
        end
    end

    // ==============================
    // Control outputs
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else begin
            // Only a fresh brew from confirm, not a return from abort
            ctrl.start_brewing <= (menu_state == ST_CONFIRM) && (next_state == ST_BREWING);
            ctrl.maintenance_mode <= menu_state inside {ST_MAINTENANCE, ST_MAINT_OPTIONS,
                ST_MAINT_VIEW_ERRORS, ST_MAINT_MANUAL_CHECK};
            ctrl.manual_check <= (menu_state == ST_MAINT_MANUAL_CHECK) && events.select;
            ctrl.display_refresh <= state_changed;
        end
    end

endmodule

`default_nettype wire

/* logic/option_selector.sv */
/*
 * Option selector
 * Wrapping left/right cursors for coffee bin, drink, size and the
 * maintenance option, each active only on its own screen
 */
`timescale 1ns/1ps
`default_nettype none

module option_selector (
    input  logic                          clk,
    input  logic                          rst_n,
    input  brew_menu_pkg::menu_state_e    menu_state,
    input  brew_menu_pkg::button_events_t events,
    output brew_menu_pkg::selection_t     selection
);

    import brew_menu_pkg::*;

    // One cursor step, left wins over right
    function automatic int wrap_step(int cur, int len, logic dn, logic up);
        return dn ? ((cur == 0) ? len - 1 : cur - 1)
             : up ? ((cur >= len - 1) ? 0 : cur + 1)
             : cur;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            selection.coffee_bin <= 3'd0;
            selection.drink      <= DRINK_BLACK_COFFEE;
            selection.size       <= SIZE_12OZ;
            selection.maint_opt  <= MAINT_VIEW_ERRORS;
        end else begin
            case (menu_state)
                ST_COFFEE_SELECT: begin
                    selection.coffee_bin <= 3'(wrap_step(int'(selection.coffee_bin),
                        NUM_COFFEE_BINS, events.left, events.right));
                end
                ST_DRINK_SELECT: begin
                    selection.drink <= drink_e'(wrap_step(int'(selection.drink),
                        NUM_DRINKS, events.left, events.right));
                end
                ST_SIZE_SELECT: begin
                    selection.size <= size_e'(wrap_step(int'(selection.size),
                        NUM_SIZES, events.left, events.right));
                end
                ST_MAINT_OPTIONS: begin
                    selection.maint_opt <= maint_opt_e'(wrap_step(int'(selection.maint_opt),
                        NUM_MAINT_OPTIONS, events.left, events.right));
                end
                default: begin
                    // Cursors hold on every other screen
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* sim/brew_menu_sva.sv */
/*
 * Menu FSM assertions
 * Strobe width, brew start entry and unused state code checks
 */
`timescale 1ns/1ps
`default_nettype none

module brew_menu_sva (
    input logic                       clk,
    input logic                       rst_n,
    input brew_menu_pkg::menu_state_e menu_state,
    input brew_menu_pkg::menu_ctrl_t  ctrl
);

    import brew_menu_pkg::*;

    // Brew command lasts one cycle
    a_brew_single: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.start_brewing |=> !ctrl.start_brewing)
        else $error("start_brewing stayed high for two cycles");

    a_check_single: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.manual_check |=> !ctrl.manual_check)
        else $error("manual_check stayed high for two cycles");

    // Strobe lands with the move from confirm into brewing
    a_brew_entry: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.start_brewing |-> (menu_state == ST_BREWING) && ($past(menu_state) == ST_CONFIRM))
        else $error("start_brewing seen without entering brewing from confirm");

    // Old settings code, never used
    a_no_settings: assert property (@(posedge clk) disable iff (!rst_n)
        4'(menu_state) != 4'd8)
        else $error("menu_state reached the unused code 8");

endmodule

`default_nettype wire

/* sim/brew_menu_tb.sv */
/*
 * Brew menu testbench
 * Replays the command trace against the menu top level, checks states,
 * selections and control strobes, and reports one line per test
 */
`timescale 1ns/1ps
`default_nettype none

module brew_menu_tb;

    import brew_menu_pkg::*;

    // Per-wait limit and whole-run limit, in clock cycles
    localparam int WAIT_LIMIT = 300;
    localparam int RUN_LIMIT  = 20000;

    // Timed resource message length given to the DUT
    localparam int INSUFF_CYCLES = 40;

    logic            clk;
    logic            rst_n;
    button_raw_t     buttons;
    machine_status_t status;
    menu_state_e     menu_state;
    selection_t      selection;
    menu_ctrl_t      ctrl;

    // Strobe totals, and the totals seen at the last count check
    int brew_pulses  = 0;
    int check_pulses = 0;
    int brew_seen    = 0;
    int check_seen   = 0;

    // State one and two samples back
    menu_state_e state_d1 = ST_SPLASH;
    menu_state_e state_d2 = ST_SPLASH;

    // Current insufficient visit, its length and any cancel seen
    int   insuff_len    = 0;
    logic insuff_cancel = 1'b0;

    int errors       = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    brew_menu_top #(
        .DEBOUNCE_CYCLES     (4),
        .COMBO_HOLD_CYCLES   (8),
        .INSUFFICIENT_TIMEOUT(INSUFF_CYCLES)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .buttons   (buttons),
        .status    (status),
        .menu_state(menu_state),
        .selection (selection),
        .ctrl      (ctrl)
    );

    bind menu_fsm brew_menu_sva i_sva (
        .clk       (clk),
        .rst_n     (rst_n),
        .menu_state(menu_state),
        .ctrl      (ctrl)
    );

    // ==============================
    // Clock, strobe counters, watchdog
    // ==============================
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Values seen here are the ones from before this edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (ctrl.start_brewing) begin
                brew_pulses++;
            end
            if (ctrl.manual_check) begin
                check_pulses++;
            end
            // Refresh trails the state change by two register stages
            assert (ctrl.display_refresh == (state_d1 != state_d2)) else begin
                $display("Fail display_refresh expected %h got %h",
                    state_d1 != state_d2, ctrl.display_refresh);
                test_errors++;
            end
            // Resource message runs its full time unless cancelled
            if (menu_state == ST_INSUFFICIENT) begin
                insuff_len++;
                if (buttons.cancel) begin
                    insuff_cancel = 1'b1;
                end
            end else if (insuff_len > 0) begin
                if (insuff_cancel) begin
                    assert (insuff_len < INSUFF_CYCLES) else begin
                        $display("Cancel did not cut the insufficient screen short");
                        test_errors++;
                    end
                end else begin
                    assert (insuff_len == INSUFF_CYCLES) else begin
                        $display("Fail insufficient duration expected %h got %h",
                            INSUFF_CYCLES, insuff_len);
                        test_errors++;
                    end
                end
                insuff_len    = 0;
                insuff_cancel = 1'b0;
            end
        end
        state_d2 = state_d1;
        state_d1 = menu_state;
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("Watchdog expired before the trace finished");
        $display("Done: errors found");
        $finish;
    end

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic button_raw_t button_mask(input logic [63:0] name);
        button_raw_t mask;
        mask = '0;
        if (name == 64'("cancel")) mask.cancel = 1'b1;
        if (name == 64'("left"))   mask.left   = 1'b1;
        if (name == 64'("right"))  mask.right  = 1'b1;
        if (name == 64'("select")) mask.select = 1'b1;
        return mask;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Ten cycles down, ten up
    task automatic press_button(input button_raw_t mask);
        @(posedge clk);
        buttons <= mask;
        repeat (10) @(posedge clk);
        buttons <= '0;
        repeat (10) @(posedge clk);
    endtask

    // Right with select, long enough for several combo strobes
    task automatic hold_combo();
        button_raw_t mask;
        mask        = '0;
        mask.right  = 1'b1;
        mask.select = 1'b1;
        @(posedge clk);
        buttons <= mask;
        repeat (30) @(posedge clk);
        buttons <= '0;
        repeat (10) @(posedge clk);
    endtask

    // Too short for the debouncer
    task automatic glitch_button(input button_raw_t mask);
        @(posedge clk);
        buttons <= mask;
        repeat (2) @(posedge clk);
        buttons <= '0;
        repeat (10) @(posedge clk);
    endtask

    task automatic set_status(input logic [4:0] value);
        @(posedge clk);
        status <= machine_status_t'(value);
    endtask

    // ==============================
    // Checks, sampled on the falling edge
    // ==============================
    task automatic wait_state(input logic [3:0] st, input logic [9:0] sel);
        int waited;
        waited = 0;
        @(negedge clk);
        while (menu_state != st && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (menu_state == st) else begin
            $display("Timed out waiting for menu_state %h, it stayed at %h", st, menu_state);
            test_errors++;
        end
        assert (selection == sel) else begin
            $display("Fail selection expected %h got %h", sel, selection);
            test_errors++;
        end
    endtask

    task automatic wait_mode(input logic level);
        int waited;
        waited = 0;
        @(negedge clk);
        while (ctrl.maintenance_mode != level && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (ctrl.maintenance_mode == level) else begin
            $display("Timed out waiting for maintenance_mode to become %h", level);
            test_errors++;
        end
    endtask

    // Strobes since the previous count check
    task automatic check_pulses_since(input int brews, input int checks);
        @(negedge clk);
        assert (brew_pulses - brew_seen == brews) else begin
            $display("Fail start_brewing count expected %h got %h",
                brews, brew_pulses - brew_seen);
            test_errors++;
        end
        assert (check_pulses - check_seen == checks) else begin
            $display("Fail manual_check count expected %h got %h",
                checks, check_pulses - check_seen);
            test_errors++;
        end
        brew_seen  = brew_pulses;
        check_seen = check_pulses;
    endtask

    task automatic finish_test(input logic [63:0] name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0s: pass", name);
        end else begin
            $display("Test %0s: FAILED with %0d errors", name, test_errors);
            tests_failed++;
        end
        errors      += test_errors;
        test_errors = 0;
    endtask

    // ==============================
    // Trace player
    // ==============================
    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  cmd;
        logic [63:0] name;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        button_raw_t mask;

        buttons = '0;
        status  = '0;
        rst_n   = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("sim/brew_menu_trace.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the trace file");
            errors++;
        end

        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
                cmd = line[0];
                case (cmd)
                    "P", "G": begin
                        n    = $sscanf(line, "%c %s", cmd, name);
                        mask = button_mask(name);
                        if (mask == '0) begin
                            $display("Unknown button name in the trace");
                            test_errors++;
                        end else if (cmd == "P") begin
                            press_button(mask);
                        end else begin
                            glitch_button(mask);
                        end
                    end
                    "C": hold_combo();
                    "S": begin
                        n = $sscanf(line, "%c %h", cmd, arg_a);
                        set_status(arg_a[4:0]);
                    end
                    "W": begin
                        n = $sscanf(line, "%c %h", cmd, arg_a);
                        idle_cycles(int'(arg_a));
                    end
                    "E": begin
                        n = $sscanf(line, "%c %h %h", cmd, arg_a, arg_b);
                        wait_state(arg_a[3:0], arg_b[9:0]);
                    end
                    "M": begin
                        n = $sscanf(line, "%c %h", cmd, arg_a);
                        wait_mode(arg_a[0]);
                    end
                    "N": begin
                        n = $sscanf(line, "%c %h %h", cmd, arg_a, arg_b);
                        check_pulses_since(int'(arg_a), int'(arg_b));
                    end
                    "T": begin
                        n = $sscanf(line, "%c %s", cmd, name);
                        finish_test(name);
                    end
                    "#", "\n", "\r", " ": begin
                        // Comment or blank line
                    end
                    default: begin
                        $display("Unrecognized command in the trace");
                        test_errors++;
                    end
                endcase
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        // Anything after the last test marker still counts
        errors += test_errors;

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
            tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/brew_menu_trace.txt */
# cmd args: P/G button, C, S status, W cycles, E state selection, M level, N brews checks, T name
# status {active,error,recipe,can,pressure}; selection {bin[2:0],drink[2:0],size[1:0],maint[1:0]}
S 03
E 0 004
P select
E 2 004
P right
P right
E 2 004
P select
E 3 004
P left
E 3 044
P select
E 4 044
P select
E 5 044
S 07
P select
E 6 044
N 1 0
S 17
W 4
S 07
E 7 044
P left
E 0 044
N 0 0
T brewflow
# Insufficient resources, timeout then cancel
S 03
P select
E 2 044
P select
P select
P select
E 5 044
P select
E a 044
E 5 044
P select
E a 044
P cancel
E 5 044
N 0 0
T insuff
# Brew guard and abort
S 07
P select
E 6 044
N 1 0
W 14
E 6 044
P cancel
E b 044
P cancel
E 6 044
N 0 0
P cancel
E b 044
P select
E 0 044
T abort
# Maintenance menu
S 03
C
E d 044
M 1
P right
E d 045
P select
E f 045
P select
E d 045
N 0 1
P left
E d 044
P left
E d 047
P left
E d 046
P select
E e 046
P cancel
E d 046
P right
E d 047
P select
E 0 047
M 0
N 0 0
T maint
# Error handling
S 0b
P select
E 0 047
S 00
P select
E 1 047
S 03
E 2 047
P cancel
E 0 047
S 00
P select
E 1 047
S 08
E 9 047
S 00
W 0a
E 9 047
S 02
E 0 047
N 0 0
T errors
# Debounce glitch
S 03
G select
W 0a
E 0 047
N 0 0
T debounce
